// File: lanzonesPkg.sv
package lanzonesPkg;

   parameter int XLEN       = 32;
   parameter int REG_ADDR_W = 5;

   typedef logic [XLEN-1:0]       word_t;
   typedef logic [REG_ADDR_W-1:0] regAddr_t;

   // what the execute cycle has to do
   typedef enum logic [2:0] {
      NOP  = 3'd0,
      LUI  = 3'd1,
      ADD  = 3'd2,
      LW   = 3'd3,
      SW   = 3'd4,
      HALT = 3'd5
   } opKind_t;

   // RV32 major opcodes, plus the all-ones halt word
   parameter logic [6:0] OPC_LUI   = 7'b0110111;
   parameter logic [6:0] OPC_OP    = 7'b0110011;
   parameter logic [6:0] OPC_STORE = 7'b0100011;
   parameter logic [6:0] OPC_LOAD  = 7'b0000011;
   parameter logic [6:0] OPC_HALT  = 7'b1111111;

endpackage

// File: coreIfs.sv
interface decodedIf;
   import lanzonesPkg::*;

   opKind_t  kind;
   regAddr_t rd;
   regAddr_t rs1;
   regAddr_t rs2;
   word_t    imm;   // already placed and sign-extended

   modport driver (output kind, rd, rs1, rs2, imm);
   modport reader (input kind, rd, rs1, rs2, imm);
endinterface

interface memAccessIf;
   import lanzonesPkg::*;

   logic  req;     // one-cycle pulse in execute
   logic  write;
   word_t addr;
   word_t wData;
   logic  done;    // pulses with the vld of the data phase

   modport requester (output req, write, addr, wData, input done);
   modport bus (input req, write, addr, wData, output done);
endinterface

// File: busControl.sv
module busControl (
   input  logic               clk,
   input  logic               rstn,
   input  logic               vld,
   input  logic               lEn,
   input  lanzonesPkg::word_t rData,
   output logic               rdy,
   output logic               wEn,
   output logic               halt,
   output lanzonesPkg::word_t addr,
   output lanzonesPkg::word_t wData,
   output lanzonesPkg::word_t instr,
   output logic               execStrobe,
   memAccessIf.bus            mem,
   decodedIf.reader           dec
);
   import lanzonesPkg::*;

   typedef enum logic [1:0] {
      PH_IDLE,
      PH_FETCH,
      PH_EXEC,
      PH_DATA
   } busPhase_t;

   busPhase_t phase;
   word_t     pc;   // word address

   assign execStrobe = (phase == PH_EXEC);
   assign mem.done   = (phase == PH_DATA) && vld;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         phase <= PH_IDLE;
         pc    <= '0;
         halt  <= 1'b1;
         rdy   <= 1'b0;
         wEn   <= 1'b0;
      end else begin
         case (phase)
            PH_IDLE: begin
               if (halt) begin
                  if (lEn) begin
                     halt <= 1'b0;   // fetch starts one edge later
                  end
               end else begin
                  rdy   <= 1'b1;
                  phase <= PH_FETCH;
               end
            end
            PH_FETCH: begin
               if (vld) begin
                  rdy   <= 1'b0;
                  pc    <= pc + 1'b1;
                  phase <= PH_EXEC;
               end
            end
            PH_EXEC: begin
               if (mem.req) begin
                  rdy   <= 1'b1;
                  wEn   <= mem.write;
                  phase <= PH_DATA;
               end else begin
                  if (dec.kind == HALT) begin
                     halt <= 1'b1;
                  end
                  phase <= PH_IDLE;
               end
            end
            PH_DATA: begin
               if (vld) begin
                  rdy   <= 1'b0;
                  wEn   <= 1'b0;
                  phase <= PH_IDLE;
               end
            end
         endcase
      end
   end

   // address and data only move while rdy is low
   always_ff @(posedge clk) begin
      if (phase == PH_IDLE) begin
         addr <= pc;
      end
      if (phase == PH_EXEC && mem.req) begin
         addr  <= mem.addr;
         wData <= mem.wData;
      end
      if (phase == PH_FETCH && vld) begin
         instr <= rData;
      end
   end

endmodule

// File: instrDecode.sv
module instrDecode (
   input  lanzonesPkg::word_t instr,
   decodedIf.driver           dec
);
   import lanzonesPkg::*;

   logic [6:0] opcode;

   assign opcode  = instr[6:0];
   assign dec.rd  = instr[11:7];
   assign dec.rs1 = instr[19:15];
   assign dec.rs2 = instr[24:20];

   always_comb begin
      dec.kind = NOP;   // unknown opcodes fall through as no-ops
      dec.imm  = '0;
      case (opcode)
         OPC_LUI: begin
            dec.kind = LUI;
            dec.imm  = {instr[31:12], 12'b0};
         end
         OPC_OP: begin
            dec.kind = ADD;
         end
         OPC_LOAD: begin
            dec.kind = LW;
            dec.imm  = {{(XLEN-12){instr[31]}}, instr[31:20]};
         end
         OPC_STORE: begin
            dec.kind = SW;
            // S-type splits the offset around rd
            dec.imm  = {{(XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
         end
         OPC_HALT: begin
            dec.kind = HALT;
         end
         default: begin
            dec.kind = NOP;
         end
      endcase
   end

endmodule

// File: regFile.sv
module regFile #(
   parameter int NumRegs = 32
) (
   input  logic                   clk,
   input  logic                   rstn,
   input  logic                   wEn,
   input  lanzonesPkg::regAddr_t  wAddr,
   input  lanzonesPkg::word_t     wData,
   output lanzonesPkg::word_t     rData1,
   output lanzonesPkg::word_t     rData2,
   decodedIf.reader               dec
);
   import lanzonesPkg::*;

   localparam int IdxW = $clog2(NumRegs);

   word_t regs [NumRegs];

   // indices past the array read as zero
   assign rData1 = (int'(dec.rs1) < NumRegs) ? regs[dec.rs1[IdxW-1:0]] : '0;
   assign rData2 = (int'(dec.rs2) < NumRegs) ? regs[dec.rs2[IdxW-1:0]] : '0;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < NumRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (wEn && wAddr != '0 && int'(wAddr) < NumRegs) begin
         regs[wAddr[IdxW-1:0]] <= wData;   // x0 stays zero
      end
   end

endmodule

// File: execUnit.sv
module execUnit (
   input  logic                  clk,
   input  logic                  rstn,
   input  logic                  execStrobe,
   input  lanzonesPkg::word_t    rData,
   input  lanzonesPkg::word_t    rData1,
   input  lanzonesPkg::word_t    rData2,
   decodedIf.reader              dec,
   memAccessIf.requester         mem,
   output logic                  wEn,
   output lanzonesPkg::regAddr_t wAddr,
   output lanzonesPkg::word_t    wData
);
   import lanzonesPkg::*;

   word_t    operandB;
   word_t    sum;
   logic     isMem;
   logic     loadPend;
   regAddr_t loadRd;

   // one adder for ADD and for the load/store address
   assign operandB = (dec.kind == ADD) ? rData2 : dec.imm;
   assign sum      = rData1 + operandB;

   assign isMem     = (dec.kind == LW) || (dec.kind == SW);
   assign mem.req   = execStrobe && isMem;
   assign mem.write = (dec.kind == SW);
   assign mem.addr  = sum;
   assign mem.wData = rData2;   // store data from rs2

   always_ff @(posedge clk) begin
      if (!rstn) begin
         loadPend <= 1'b0;
      end else if (mem.req && dec.kind == LW) begin
         loadPend <= 1'b1;
      end else if (mem.done) begin
         loadPend <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (mem.req && dec.kind == LW) begin
         loadRd <= dec.rd;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wEn <= 1'b0;
      end else begin
         wEn <= (execStrobe && (dec.kind == LUI || dec.kind == ADD))
                || (mem.done && loadPend);
      end
   end

   // write-back payload
   always_ff @(posedge clk) begin
      if (execStrobe && dec.kind == LUI) begin
         wAddr <= dec.rd;
         wData <= dec.imm;
      end else if (execStrobe && dec.kind == ADD) begin
         wAddr <= dec.rd;
         wData <= sum;   // wraps mod 2^32
      end else if (mem.done && loadPend) begin
         wAddr <= loadRd;
         wData <= rData;
      end
   end

endmodule

// File: lanzonesCore.sv
module lanzonesCore #(
   parameter int NumRegs = 32
) (
   input  logic               clk,
   input  logic               rstn,
   input  logic               vld,
   input  logic               lEn,
   input  lanzonesPkg::word_t rData,
   output logic               rdy,
   output logic               wEn,
   output logic               halt,
   output lanzonesPkg::word_t addr,
   output lanzonesPkg::word_t wData
);
   import lanzonesPkg::*;

   word_t    instr;
   logic     execStrobe;
   logic     rfWEn;
   regAddr_t rfWAddr;
   word_t    rfWData;
   word_t    rData1;
   word_t    rData2;

   decodedIf   decIf ();
   memAccessIf memIf ();

   busControl u_busControl (
      .clk        (clk),
      .rstn       (rstn),
      .vld        (vld),
      .lEn        (lEn),
      .rData      (rData),
      .rdy        (rdy),
      .wEn        (wEn),
      .halt       (halt),
      .addr       (addr),
      .wData      (wData),
      .instr      (instr),
      .execStrobe (execStrobe),
      .mem        (memIf.bus),
      .dec        (decIf.reader)
   );

   instrDecode u_instrDecode (
      .instr (instr),
      .dec   (decIf.driver)
   );

   regFile #(
      .NumRegs (NumRegs)
   ) u_regFile (
      .clk    (clk),
      .rstn   (rstn),
      .wEn    (rfWEn),
      .wAddr  (rfWAddr),
      .wData  (rfWData),
      .rData1 (rData1),
      .rData2 (rData2),
      .dec    (decIf.reader)
   );

   execUnit u_execUnit (
      .clk        (clk),
      .rstn       (rstn),
      .execStrobe (execStrobe),
      .rData      (rData),   // load data straight off the bus
      .rData1     (rData1),
      .rData2     (rData2),
      .dec        (decIf.reader),
      .mem        (memIf.requester),
      .wEn        (rfWEn),
      .wAddr      (rfWAddr),
      .wData      (rfWData)
   );

endmodule

// File: lanzonesCore_chk.sv
module lanzonesCore_chk (
   input logic               clk,
   input logic               rstn,
   input logic               rdy,
   input logic               vld,
   input logic               halt,
   input logic               wEn,
   input lanzonesPkg::word_t addr,
   input lanzonesPkg::word_t wData
);
   timeunit 1ns;
   timeprecision 1ps;

   noRdyWhileHalted: assert property (@(posedge clk) disable iff (!rstn) halt |-> !rdy)
      else $error("rdy is high while the core is halted");

   // store data only matters on a write
   requestStable: assert property (@(posedge clk) disable iff (!rstn)
      (rdy && !vld) |=> ($stable(addr) && $stable(wEn) && (!wEn || $stable(wData))))
      else $error("bus request changed before vld");

   rdyFallsAfterVld: assert property (@(posedge clk) disable iff (!rstn) vld |=> !rdy)
      else $error("rdy still high the cycle after vld");

endmodule

bind lanzonesCore lanzonesCore_chk u_chk (.*);

// File: tbMonitor.sv
module tbMonitor (
   input logic               clk,
   input logic               rstn,
   input logic               idleCheck,
   input logic               rdy,
   input logic               wEn,
   input logic               vld,
   input logic               halt,
   input lanzonesPkg::word_t addr,
   input lanzonesPkg::word_t wData
);
   timeunit 1ns;
   timeprecision 1ps;
   import lanzonesPkg::*;

   word_t expAddr [$];
   word_t expData [$];
   int    caseIdx     = 0;
   int    caseErrors  = 0;
   int    errors      = 0;
   int    casesRun    = 0;
   int    casesFailed = 0;

   task automatic beginCase(input int idx);
      caseIdx    = idx;
      caseErrors = 0;
      expAddr.delete();
      expData.delete();
   endtask

   task automatic expectStore(input word_t a, input word_t d);
      expAddr.push_back(a);
      expData.push_back(d);
   endtask

   task automatic reportMismatch(input string name, input word_t expected, input word_t actual);
      $display("[ERROR] %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      caseErrors++;
   endtask

   task automatic finishCase();
      if (expAddr.size() != 0) begin
         $display("case %0d: %0d expected store(s) never appeared on the bus",
                  caseIdx, expAddr.size());
         caseErrors++;
      end
      errors += caseErrors;
      casesRun++;
      if (caseErrors == 0) begin
         $display("case %0d: ok", caseIdx);
      end else begin
         casesFailed++;
         $display("case %0d: FAILED with %0d errors", caseIdx, caseErrors);
      end
   endtask

   always @(posedge clk) begin
      if (rstn) begin
         if (idleCheck && halt !== 1'b1) begin   // before lEn the core must sit halted
            reportMismatch("halt", 32'd1, {31'b0, halt});
         end
         if (halt && rdy !== 1'b0) begin
            reportMismatch("rdy", '0, {31'b0, rdy});
         end
         if (halt && wEn !== 1'b0) begin
            reportMismatch("wEn", '0, {31'b0, wEn});
         end
         if (rdy && wEn && vld) begin
            if (expAddr.size() == 0) begin
               $display("case %0d: unexpected store of %h to address %h at %0t ns",
                        caseIdx, wData, addr, $time);
               caseErrors++;
            end else begin
               if (addr !== expAddr[0]) begin
                  reportMismatch("addr", expAddr[0], addr);
               end
               if (wData !== expData[0]) begin
                  reportMismatch("wData", expData[0], wData);
               end
               void'(expAddr.pop_front());
               void'(expData.pop_front());
            end
         end
      end
   end

endmodule

// File: tb_lanzonesCore.sv
module tb_lanzonesCore;
   timeunit 1ns;
   timeprecision 1ps;
   import lanzonesPkg::*;

   localparam int MemWords    = 256;
   localparam int ResetCycles = 10;
   localparam int IdleCycles  = 3;
   localparam int DrainCycles = 3;
   localparam int InstrBudget = 12;   // worst case cycles per instruction
   localparam int CaseBudget  = 20;   // reset, lEn and drain

   logic  clk = 1'b0;
   logic  rstn;
   logic  vld;
   logic  lEn;
   word_t rData;
   logic  rdy;
   logic  wEn;
   logic  halt;
   word_t addr;
   word_t wData;
   logic  idleCheck;

   word_t       mem [MemWords];
   word_t       caseWords [512];
   logic [31:0] lfsr;
   int          cycles     = 0;
   int          cycleLimit = 0;

   lanzonesCore #(
      .NumRegs (32)
   ) u_dut (
      .clk   (clk),
      .rstn  (rstn),
      .vld   (vld),
      .lEn   (lEn),
      .rData (rData),
      .rdy   (rdy),
      .wEn   (wEn),
      .halt  (halt),
      .addr  (addr),
      .wData (wData)
   );

   tbMonitor u_mon (
      .clk       (clk),
      .rstn      (rstn),
      .idleCheck (idleCheck),
      .rdy       (rdy),
      .wEn       (wEn),
      .vld       (vld),
      .halt      (halt),
      .addr      (addr),
      .wData     (wData)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycleLimit) begin
         $display("timeout: the core stalled and did not finish within %0d cycles", cycleLimit);
         $display("Some tests failed");
         $finish;
      end
   end

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] stepLfsr(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic fillMemory();
      for (int a = 0; a < MemWords; a++) begin
         mem[a] = 32'hA5A50000 | (a * 32'h00000101);
      end
   endtask

   task automatic answerRequest();
      vld <= 1'b1;
      if (wEn) begin
         mem[addr[7:0]] = wData;
      end else begin
         rData <= mem[addr[7:0]];
      end
   endtask

   // memory model serving one request at a time in 1 to 4 cycles
   task automatic serveBus();
      int         countdown;
      logic       busy;
      logic       finished;
      logic [1:0] extra;
      countdown = 0;
      busy      = 1'b0;
      finished  = 1'b0;
      while (!finished) begin
         @(posedge clk);
         if (vld) begin
            vld <= 1'b0;
            busy = 1'b0;
         end else if (busy) begin
            countdown--;
            if (countdown == 0) begin
               answerRequest();
            end
         end else if (rdy) begin
            extra[0]  = lfsr[31];
            lfsr      = stepLfsr(lfsr);
            extra[1]  = lfsr[31];
            lfsr      = stepLfsr(lfsr);
            busy      = 1'b1;
            countdown = int'(extra);
            if (countdown == 0) begin
               answerRequest();
            end
         end else if (halt) begin
            finished = 1'b1;
         end
      end
   endtask

   task automatic runCase(input int idx, inout int p);
      int nProg;
      int nData;
      int nStore;
      nProg  = int'(caseWords[p]);
      nData  = int'(caseWords[p+1]);
      nStore = int'(caseWords[p+2]);
      p += 3;
      u_mon.beginCase(idx);
      @(posedge clk);
      rstn <= 1'b0;
      repeat (ResetCycles) @(posedge clk);
      rstn      <= 1'b1;
      idleCheck <= 1'b1;
      fillMemory();
      for (int i = 0; i < nProg + nData; i++) begin   // program and data alike
         mem[caseWords[p][7:0]] = caseWords[p+1];
         p += 2;
      end
      for (int i = 0; i < nStore; i++) begin
         u_mon.expectStore(caseWords[p], caseWords[p+1]);
         p += 2;
      end
      repeat (IdleCycles) @(posedge clk);
      idleCheck <= 1'b0;
      lEn       <= 1'b1;
      @(posedge clk);
      lEn <= 1'b0;
      serveBus();
      repeat (DrainCycles) @(posedge clk);   // nothing may move after halt
      @(negedge clk);
      u_mon.finishCase();
   endtask

   initial begin
      int p;
      int nCases;
      int totalInstr;
      rstn      = 1'b0;
      vld       = 1'b0;
      lEn       = 1'b0;
      rData     = '0;
      idleCheck = 1'b0;
      lfsr      = 32'h5915cf74;
      $readmemh("lanzones_cases.txt", caseWords);
      if ($isunknown(caseWords[0]) || caseWords[0] == '0) begin
         $display("the case file lanzones_cases.txt is missing or holds no cases");
         $display("Some tests failed");
      end else begin
         nCases     = int'(caseWords[0]);
         totalInstr = 0;
         p          = 1;
         for (int c = 0; c < nCases; c++) begin
            totalInstr += int'(caseWords[p]);
            p += 3 + 2 * int'(caseWords[p] + caseWords[p+1] + caseWords[p+2]);
         end
         cycleLimit = totalInstr * InstrBudget + nCases * CaseBudget;
         p = 1;
         for (int c = 1; c <= nCases; c++) begin
            runCase(c, p);
         end
         $display("%0d cases run, %0d failed, %0d errors",
                  u_mon.casesRun, u_mon.casesFailed, u_mon.errors);
         if (u_mon.errors == 0 && u_mon.casesRun == nCases) begin
            $display("All tests passed");
         end else begin
            $display("Some tests failed");
         end
      end
      $finish;
   end

endmodule

// File: lanzones_cases.txt
// first word: number of cases; per case a header "program data stores" (word counts)
// then program and data words as "addr word", then expected stores as "addr data"
5
// case 1: LUI then SW
3 0 1
0 123450B7  1 08102023  2 0000007F
80 12345000
// case 2: ADD of two LUI values with wrap, SW with positive and negative offset
7 1 2
0 FFFFF0B7  1 00003137  2 002081B3  3 04002203
4 083020A3  5 FE322C23  6 0000007F
40 000000A0
81 00002000  98 00002000
// case 3: two LW, ADD, SW
5 2 1
0 05002083  1 05102103  2 002081B3  3 08302823  4 0000007F
50 7FFFFFFF  51 00000005
90 80000004
// case 4: x0 as destination and as source
7 0 2
0 ABCDE037  1 0A002023  2 000010B7  3 00108033
4 00100133  5 0A2020A3  6 0000007F
A0 00000000  A1 00001000
// case 5: unknown opcode, HALT, then a store that must never run
5 0 1
0 000550B7  1 0A102823  2 00000013  3 0000007F  4 0A1028A3
B0 00055000

// File: lanzonesCore.f
lanzonesPkg.sv
coreIfs.sv
busControl.sv
instrDecode.sv
regFile.sv
execUnit.sv
lanzonesCore.sv
lanzonesCore_chk.sv
tbMonitor.sv
tb_lanzonesCore.sv

// File: run.sh
#!/usr/bin/env bash
# builds and runs the lanzonesCore testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_lanzonesCore \
   -f lanzonesCore.f -o simLanzones
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/simLanzones > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "All tests passed" "$LOG"; then
   exit 0
fi
exit 1
